/* design/isa_pkg.sv */
package isa_pkg;

   localparam int WORD_W = 32;
   localparam int TAG_W  = 6;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0]  tag_t;
   typedef logic [5:0]        opcode_t;
   typedef logic [5:0]        funct_t;
   typedef logic [3:0]        alu_op_t;

   // major opcodes
   localparam opcode_t OPCODE_RTYPE = 6'h00;
   localparam opcode_t OPCODE_BEQ   = 6'h04;
   localparam opcode_t OPCODE_BNE   = 6'h05;

   // r-type function field
   localparam funct_t FUNCT_ADD  = 6'h20;
   localparam funct_t FUNCT_ADDU = 6'h21;
   localparam funct_t FUNCT_SUB  = 6'h22;
   localparam funct_t FUNCT_SUBU = 6'h23;
   localparam funct_t FUNCT_AND  = 6'h24;
   localparam funct_t FUNCT_OR   = 6'h25;
   localparam funct_t FUNCT_NOR  = 6'h27;
   localparam funct_t FUNCT_SLT  = 6'h2a;
   localparam funct_t FUNCT_SLTU = 6'h2b;

   // internal alu operations, add/addu and sub/subu collapse to one each
   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_AND  = 4'd2;
   localparam alu_op_t ALU_OR   = 4'd3;
   localparam alu_op_t ALU_NOR  = 4'd4;
   localparam alu_op_t ALU_SLT  = 4'd5;
   localparam alu_op_t ALU_SLTU = 4'd6;
   localparam alu_op_t ALU_BEQ  = 4'd7;
   localparam alu_op_t ALU_BNE  = 4'd8;

endpackage

/* design/issue_pkg.sv */
package issue_pkg;

   // entries in the issue queue, also the dispatch credit pool
   localparam int ISSUE_DEPTH = 4;

   // holds 0 to ISSUE_DEPTH
   typedef logic [2:0] credit_t;

   // wraps naturally at ISSUE_DEPTH
   typedef logic [1:0] qptr_t;

endpackage

/* design/cla_adder.sv */
module cla_adder (
   input  isa_pkg::word_t a,
   input  isa_pkg::word_t b,
   input  logic           carry_in,
   output isa_pkg::word_t sum,
   output logic           carry_out,
   output logic           overflow
);
   import isa_pkg::*;

   localparam int NGRP = WORD_W / 4;

   word_t           g;
   word_t           p;
   word_t           c;        // carry into each bit
   logic [NGRP-1:0] grp_g;
   logic [NGRP-1:0] grp_p;
   logic [NGRP:0]   grp_c;    // carry into each group

   assign g = a & b;
   assign p = a ^ b;

   for (genvar k = 0; k < NGRP; k++) begin : g_grp
      localparam int B = 4 * k;

      assign grp_g[k] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                      | (p[B+3] & p[B+2] & p[B+1] & g[B]);
      assign grp_p[k] = &p[B+3:B];

      // first level lookahead inside the group
      assign c[B]   = grp_c[k];
      assign c[B+1] = g[B] | (p[B] & grp_c[k]);
      assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & grp_c[k]);
      assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                    | (p[B+2] & p[B+1] & p[B] & grp_c[k]);
   end

   // second level, each group carry flattened from G/P and carry_in
   always_comb begin
      logic acc;
      logic run;
      grp_c[0] = carry_in;
      for (int k = 0; k < NGRP; k++) begin
         acc = grp_g[k];
         run = grp_p[k];
         for (int j = k - 1; j >= 0; j--) begin
            acc = acc | (run & grp_g[j]);
            run = run & grp_p[j];
         end
         grp_c[k+1] = acc | (run & carry_in);
      end
   end

   assign sum       = p ^ c;
   assign carry_out = grp_c[NGRP];
   assign overflow  = c[WORD_W-1] ^ grp_c[NGRP];   // carry in vs out of msb

endmodule

/* design/dispatch_unit.sv */
module dispatch_unit (
   input  logic              clk,
   input  logic              reset,
   input  logic              op_valid,
   output logic              op_ready,
   input  isa_pkg::opcode_t  op_opcode,
   input  isa_pkg::funct_t   op_funct,
   input  isa_pkg::word_t    op_rs_data,
   input  isa_pkg::word_t    op_rt_data,
   input  isa_pkg::tag_t     op_tag,
   input  logic              credit_return,
   output logic              push_valid,
   output isa_pkg::alu_op_t  push_alu_op,
   output isa_pkg::word_t    push_rs_data,
   output isa_pkg::word_t    push_rt_data,
   output isa_pkg::tag_t     push_tag,
   output logic              illegal_op,
   output isa_pkg::tag_t     illegal_tag
);
   import isa_pkg::*;
   import issue_pkg::*;

   credit_t credits;
   alu_op_t dec_op;
   logic    dec_legal;
   logic    accept;
   logic    spend;

   assign op_ready = (credits != '0);
   assign accept   = op_valid && op_ready;
   assign spend    = accept && dec_legal;

   always_comb begin
      dec_op    = ALU_ADD;
      dec_legal = 1'b1;
      if (op_opcode == OPCODE_RTYPE) begin
         case (op_funct)
            FUNCT_ADD, FUNCT_ADDU: dec_op = ALU_ADD;
            FUNCT_SUB, FUNCT_SUBU: dec_op = ALU_SUB;
            FUNCT_AND:             dec_op = ALU_AND;
            FUNCT_OR:              dec_op = ALU_OR;
            FUNCT_NOR:             dec_op = ALU_NOR;
            FUNCT_SLT:             dec_op = ALU_SLT;
            FUNCT_SLTU:            dec_op = ALU_SLTU;
            default:               dec_legal = 1'b0;
         endcase
      end else if (op_opcode == OPCODE_BEQ) begin
         dec_op = ALU_BEQ;
      end else if (op_opcode == OPCODE_BNE) begin
         dec_op = ALU_BNE;
      end else begin
         dec_legal = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         push_valid <= 1'b0;
         illegal_op <= 1'b0;
         credits    <= credit_t'(ISSUE_DEPTH);
      end else begin
         push_valid <= spend;
         illegal_op <= accept && !dec_legal;
         case ({spend, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;   // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (spend) begin
         push_alu_op  <= dec_op;
         push_rs_data <= op_rs_data;
         push_rt_data <= op_rt_data;
         push_tag     <= op_tag;
      end
      illegal_tag <= op_tag;
   end

   // returns from the queue must never outnumber what was spent
   a_credit_bound: assert property (@(posedge clk) disable iff (reset)
      credits <= ISSUE_DEPTH);

endmodule

/* design/issue_queue.sv */
module issue_queue (
   input  logic              clk,
   input  logic              reset,
   input  logic              push_valid,
   input  isa_pkg::alu_op_t  push_alu_op,
   input  isa_pkg::word_t    push_rs_data,
   input  isa_pkg::word_t    push_rt_data,
   input  isa_pkg::tag_t     push_tag,
   output logic              head_valid,
   output isa_pkg::alu_op_t  head_alu_op,
   output isa_pkg::word_t    head_rs_data,
   output isa_pkg::word_t    head_rt_data,
   output isa_pkg::tag_t     head_tag,
   input  logic              pop,
   output logic              credit_return
);
   import isa_pkg::*;
   import issue_pkg::*;

   alu_op_t mem_alu_op [ISSUE_DEPTH];
   word_t   mem_rs     [ISSUE_DEPTH];
   word_t   mem_rt     [ISSUE_DEPTH];
   tag_t    mem_tag    [ISSUE_DEPTH];

   qptr_t   wr_ptr;
   qptr_t   rd_ptr;
   credit_t count;

   assign head_valid   = (count != '0);
   assign head_alu_op  = mem_alu_op[rd_ptr];
   assign head_rs_data = mem_rs[rd_ptr];
   assign head_rt_data = mem_rt[rd_ptr];
   assign head_tag     = mem_tag[rd_ptr];

   always_ff @(posedge clk) begin
      if (push_valid) begin
         mem_alu_op[wr_ptr] <= push_alu_op;
         mem_rs[wr_ptr]     <= push_rs_data;
         mem_rt[wr_ptr]     <= push_rt_data;
         mem_tag[wr_ptr]    <= push_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // one credit back per freed entry on the next cycle
         credit_return <= pop;
      end
   end

   // dispatch credits keep pushes away from a full queue
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      push_valid |-> (count != credit_t'(ISSUE_DEPTH)));

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> head_valid);

endmodule

/* design/int_exec_unit.sv */
module int_exec_unit (
   input  logic              clk,
   input  logic              reset,
   input  logic              head_valid,
   input  isa_pkg::alu_op_t  head_alu_op,
   input  isa_pkg::word_t    head_rs_data,
   input  isa_pkg::word_t    head_rt_data,
   input  isa_pkg::tag_t     head_tag,
   output logic              pop,
   input  logic              result_stall,
   output logic              result_valid,
   output isa_pkg::tag_t     result_tag,
   output isa_pkg::word_t    result_value,
   output logic              result_carry,
   output logic              result_overflow,
   output logic              result_is_branch,
   output logic              result_taken
);
   import isa_pkg::*;

   logic  use_sub;
   word_t add_b;
   word_t add_sum;
   logic  add_cout;
   logic  add_ovf;
   logic  lt_signed;
   logic  lt_unsigned;
   logic  operands_eq;

   word_t value_nxt;
   logic  carry_nxt;
   logic  ovf_nxt;
   logic  branch_nxt;
   logic  taken_nxt;

   assign pop = head_valid && !result_stall;

   // compares share the subtract path
   assign use_sub = (head_alu_op == ALU_SUB) || (head_alu_op == ALU_SLT)
                 || (head_alu_op == ALU_SLTU);
   assign add_b   = use_sub ? ~head_rt_data : head_rt_data;

   cla_adder adder_i (
      .a         (head_rs_data),
      .b         (add_b),
      .carry_in  (use_sub),
      .sum       (add_sum),
      .carry_out (add_cout),
      .overflow  (add_ovf)
   );

   assign lt_signed   = add_sum[WORD_W-1] ^ add_ovf;
   assign lt_unsigned = !add_cout;   // borrow out
   assign operands_eq = (head_rs_data == head_rt_data);

   always_comb begin
      value_nxt  = '0;
      carry_nxt  = 1'b0;
      ovf_nxt    = 1'b0;
      branch_nxt = 1'b0;
      taken_nxt  = 1'b0;
      case (head_alu_op)
         ALU_ADD, ALU_SUB: begin
            value_nxt = add_sum;
            carry_nxt = add_cout;
            ovf_nxt   = add_ovf;
         end
         ALU_AND:  value_nxt = head_rs_data & head_rt_data;
         ALU_OR:   value_nxt = head_rs_data | head_rt_data;
         ALU_NOR:  value_nxt = ~(head_rs_data | head_rt_data);
         ALU_SLT:  value_nxt = word_t'(lt_signed);
         ALU_SLTU: value_nxt = word_t'(lt_unsigned);
         ALU_BEQ: begin
            branch_nxt = 1'b1;
            taken_nxt  = operands_eq;
         end
         ALU_BNE: begin
            branch_nxt = 1'b1;
            taken_nxt  = !operands_eq;
         end
         default: value_nxt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         result_valid <= 1'b0;
      end else if (!result_stall) begin
         result_valid <= head_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         result_tag       <= head_tag;
         result_value     <= value_nxt;
         result_carry     <= carry_nxt;
         result_overflow  <= ovf_nxt;
         result_is_branch <= branch_nxt;
         result_taken     <= taken_nxt;
      end
   end

   // a stalled result stays put on the bus
   a_stall_hold: assert property (@(posedge clk) disable iff (reset)
      result_valid && result_stall |=> result_valid && $stable(result_tag)
         && $stable(result_value) && $stable(result_carry) && $stable(result_overflow)
         && $stable(result_is_branch) && $stable(result_taken));

endmodule

/* design/int_issue_top.sv */
module int_issue_top (
   input  logic              clk,
   input  logic              reset,
   input  logic              op_valid,
   output logic              op_ready,
   input  isa_pkg::opcode_t  op_opcode,
   input  isa_pkg::funct_t   op_funct,
   input  isa_pkg::word_t    op_rs_data,
   input  isa_pkg::word_t    op_rt_data,
   input  isa_pkg::tag_t     op_tag,
   output logic              illegal_op,
   output isa_pkg::tag_t     illegal_tag,
   input  logic              result_stall,
   output logic              result_valid,
   output isa_pkg::tag_t     result_tag,
   output isa_pkg::word_t    result_value,
   output logic              result_carry,
   output logic              result_overflow,
   output logic              result_is_branch,
   output logic              result_taken
);
   import isa_pkg::*;

   logic    push_valid;
   alu_op_t push_alu_op;
   word_t   push_rs_data;
   word_t   push_rt_data;
   tag_t    push_tag;
   logic    credit_return;

   logic    head_valid;
   alu_op_t head_alu_op;
   word_t   head_rs_data;
   word_t   head_rt_data;
   tag_t    head_tag;
   logic    pop;

   dispatch_unit dispatch_i (
      .clk           (clk),
      .reset         (reset),
      .op_valid      (op_valid),
      .op_ready      (op_ready),
      .op_opcode     (op_opcode),
      .op_funct      (op_funct),
      .op_rs_data    (op_rs_data),
      .op_rt_data    (op_rt_data),
      .op_tag        (op_tag),
      .credit_return (credit_return),
      .push_valid    (push_valid),
      .push_alu_op   (push_alu_op),
      .push_rs_data  (push_rs_data),
      .push_rt_data  (push_rt_data),
      .push_tag      (push_tag),
      .illegal_op    (illegal_op),
      .illegal_tag   (illegal_tag)
   );

   issue_queue queue_i (
      .clk           (clk),
      .reset         (reset),
      .push_valid    (push_valid),
      .push_alu_op   (push_alu_op),
      .push_rs_data  (push_rs_data),
      .push_rt_data  (push_rt_data),
      .push_tag      (push_tag),
      .head_valid    (head_valid),
      .head_alu_op   (head_alu_op),
      .head_rs_data  (head_rs_data),
      .head_rt_data  (head_rt_data),
      .head_tag      (head_tag),
      .pop           (pop),
      .credit_return (credit_return)
   );

   int_exec_unit exec_i (
      .clk              (clk),
      .reset            (reset),
      .head_valid       (head_valid),
      .head_alu_op      (head_alu_op),
      .head_rs_data     (head_rs_data),
      .head_rt_data     (head_rt_data),
      .head_tag         (head_tag),
      .pop              (pop),
      .result_stall     (result_stall),
      .result_valid     (result_valid),
      .result_tag       (result_tag),
      .result_value     (result_value),
      .result_carry     (result_carry),
      .result_overflow  (result_overflow),
      .result_is_branch (result_is_branch),
      .result_taken     (result_taken)
   );

endmodule

/* verification/int_issue_checker.sv */
module int_issue_checker (
   input  logic            clk,
   input  logic            reset,
   input  logic            op_valid,
   input  logic            op_ready,
   input  logic            exp_illegal,
   input  isa_pkg::tag_t   exp_tag,
   input  isa_pkg::word_t  exp_value,
   input  logic            exp_carry,
   input  logic            exp_overflow,
   input  logic            exp_is_branch,
   input  logic            exp_taken,
   input  logic            illegal_op,
   input  isa_pkg::tag_t   illegal_tag,
   input  logic            result_stall,
   input  logic            result_valid,
   input  isa_pkg::tag_t   result_tag,
   input  isa_pkg::word_t  result_value,
   input  logic            result_carry,
   input  logic            result_overflow,
   input  logic            result_is_branch,
   input  logic            result_taken,
   output int              pending,
   output int              check_count,
   output int              error_count
);
   timeunit 1ns;
   timeprecision 1ps;
   import isa_pkg::*;

   typedef struct packed {
      tag_t  tag;
      word_t value;
      logic  carry;
      logic  overflow;
      logic  is_branch;
      logic  taken;
   } result_rec_t;

   result_rec_t want_q[$];     // legal ops, in acceptance order
   tag_t        illegal_q[$];
   result_rec_t staged;
   result_rec_t want;
   tag_t        want_tag;

   initial begin
      pending     = 0;
      check_count = 0;
      error_count = 0;
   end

   task automatic compare_field(input string name, input word_t expected, input word_t actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("Error %s expected 0x%h actual 0x%h at %0t ns", name, expected, actual, $time);
      end
   endtask

   always @(posedge clk) begin
      if (!reset) begin
         if (op_valid && op_ready) begin
            if (exp_illegal) begin
               illegal_q.push_back(exp_tag);
            end else begin
               staged.tag       = exp_tag;
               staged.value     = exp_value;
               staged.carry     = exp_carry;
               staged.overflow  = exp_overflow;
               staged.is_branch = exp_is_branch;
               staged.taken     = exp_taken;
               want_q.push_back(staged);
            end
         end
         if (illegal_op) begin
            if (illegal_q.size() == 0) begin
               error_count++;
               $display("illegal_op pulsed with tag 0x%h but no illegal op is outstanding",
                        illegal_tag);
            end else begin
               want_tag = illegal_q.pop_front();
               compare_field("illegal_tag", word_t'(want_tag), word_t'(illegal_tag));
            end
         end
         // a stalled result is counted once, on the edge it leaves
         if (result_valid && !result_stall) begin
            if (want_q.size() == 0) begin
               error_count++;
               $display("result with tag 0x%h arrived but no result is outstanding", result_tag);
            end else begin
               want = want_q.pop_front();
               compare_field("result_tag", word_t'(want.tag), word_t'(result_tag));
               compare_field("result_value", want.value, result_value);
               compare_field("result_carry", word_t'(want.carry), word_t'(result_carry));
               compare_field("result_overflow", word_t'(want.overflow), word_t'(result_overflow));
               compare_field("result_is_branch", word_t'(want.is_branch),
                             word_t'(result_is_branch));
               compare_field("result_taken", word_t'(want.taken), word_t'(result_taken));
            end
         end
         pending = want_q.size() + illegal_q.size();
      end
   end

endmodule

/* verification/int_issue_tb.sv */
module int_issue_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import isa_pkg::*;
   import issue_pkg::*;

   localparam int CLK_PERIOD     = 8;
   localparam int N_RANDOM       = 300;
   localparam int TOTAL_OPS      = 14 + 4 + 2 * N_RANDOM + 9 + 2 * ISSUE_DEPTH;
   localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40;

   typedef struct packed {
      logic  illegal;
      tag_t  tag;
      word_t value;
      logic  carry;
      logic  overflow;
      logic  is_branch;
      logic  taken;
   } expect_t;

   logic    clk;
   logic    reset;
   logic    op_valid;
   logic    op_ready;
   opcode_t op_opcode;
   funct_t  op_funct;
   word_t   op_rs_data;
   word_t   op_rt_data;
   tag_t    op_tag;
   logic    illegal_op;
   tag_t    illegal_tag;
   logic    result_stall;
   logic    result_valid;
   tag_t    result_tag;
   word_t   result_value;
   logic    result_carry;
   logic    result_overflow;
   logic    result_is_branch;
   logic    result_taken;

   expect_t exp_rec;
   int      pending;
   int      check_count;
   int      error_count;
   int      stall_pct;
   int      local_errors;
   int      tests_done;
   int      errors_before;
   logic    ready_stuck;

   int_issue_top dut_i (.*);

   int_issue_checker checker_i (
      .*,
      .exp_illegal   (exp_rec.illegal),
      .exp_tag       (exp_rec.tag),
      .exp_value     (exp_rec.value),
      .exp_carry     (exp_rec.carry),
      .exp_overflow  (exp_rec.overflow),
      .exp_is_branch (exp_rec.is_branch),
      .exp_taken     (exp_rec.taken)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // stall_pct of 100 holds the result bus
   always @(negedge clk) begin
      result_stall = (($urandom % 100) < stall_pct);
   end

   function automatic expect_t expected_result(input opcode_t opc, input funct_t fn,
                                               input word_t a, input word_t b, input tag_t tag);
      expect_t     e;
      logic [32:0] wide;
      e     = '0;
      e.tag = tag;
      if (opc == OPCODE_RTYPE) begin
         case (fn)
            FUNCT_ADD, FUNCT_ADDU: begin
               wide       = {1'b0, a} + {1'b0, b};
               e.value    = wide[31:0];
               e.carry    = wide[32];
               e.overflow = (a[31] == b[31]) && (e.value[31] != a[31]);
            end
            FUNCT_SUB, FUNCT_SUBU: begin
               wide       = {1'b0, a} + {1'b0, ~b} + 33'd1;   // carry set means no borrow
               e.value    = wide[31:0];
               e.carry    = wide[32];
               e.overflow = (a[31] != b[31]) && (e.value[31] != a[31]);
            end
            FUNCT_AND:  e.value = a & b;
            FUNCT_OR:   e.value = a | b;
            FUNCT_NOR:  e.value = ~(a | b);
            FUNCT_SLT:  e.value = {31'b0, $signed(a) < $signed(b)};
            FUNCT_SLTU: e.value = {31'b0, a < b};
            default:    e.illegal = 1'b1;
         endcase
      end else if (opc == OPCODE_BEQ || opc == OPCODE_BNE) begin
         e.is_branch = 1'b1;
         e.taken     = ((a == b) == (opc == OPCODE_BEQ));
      end else begin
         e.illegal = 1'b1;
      end
      return e;
   endfunction

   task automatic send_op(input opcode_t opc, input funct_t fn, input word_t a, input word_t b,
                          input tag_t tag);
      @(negedge clk);
      op_valid   = 1'b1;
      op_opcode  = opc;
      op_funct   = fn;
      op_rs_data = a;
      op_rt_data = b;
      op_tag     = tag;
      exp_rec    = expected_result(opc, fn, a, b, tag);
      while (!op_ready) @(negedge clk);
      @(posedge clk);   // transfer edge
   endtask

   task automatic random_op();
      int      pick;
      word_t   a;
      word_t   b;
      funct_t  fn;
      opcode_t opc;
      pick = $urandom % 11;
      a    = $urandom;
      b    = $urandom;
      opc  = OPCODE_RTYPE;
      fn   = funct_t'($urandom);   // ignored by branches
      case (pick)
         0: fn = FUNCT_ADD;
         1: fn = FUNCT_ADDU;
         2: fn = FUNCT_SUB;
         3: fn = FUNCT_SUBU;
         4: fn = FUNCT_AND;
         5: fn = FUNCT_OR;
         6: fn = FUNCT_NOR;
         7: fn = FUNCT_SLT;
         8: fn = FUNCT_SLTU;
         9: opc = OPCODE_BEQ;
         default: opc = OPCODE_BNE;
      endcase
      if (pick >= 9 && ($urandom % 2) == 1) b = a;   // else taken would be rare
      send_op(opc, fn, a, b, tag_t'($urandom));
   endtask

   task automatic finish_test(input string name);
      @(negedge clk);
      op_valid = 1'b0;
      while (pending != 0) @(negedge clk);
      repeat (4) @(negedge clk);   // room for a stray result
      tests_done++;
      $display("test %0d %s finished with %0d errors", tests_done, name,
               error_count + local_errors - errors_before);
      errors_before = error_count + local_errors;
   endtask

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout, results still outstanding after %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(9974));
      clk           = 1'b0;
      reset         = 1'b1;
      op_valid      = 1'b0;
      op_opcode     = '0;
      op_funct      = '0;
      op_rs_data    = '0;
      op_rt_data    = '0;
      op_tag        = '0;
      result_stall  = 1'b0;
      exp_rec       = '0;
      stall_pct     = 0;
      local_errors  = 0;
      tests_done    = 0;
      errors_before = 0;
      ready_stuck   = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if (!op_ready) begin
         local_errors++;
         $display("op_ready is low after reset");
      end

      send_op(OPCODE_RTYPE, FUNCT_ADD,  32'h7fffffff, 32'h00000001, 6'd1);
      send_op(OPCODE_RTYPE, FUNCT_ADD,  32'hffffffff, 32'h00000001, 6'd2);
      send_op(OPCODE_RTYPE, FUNCT_ADDU, 32'h7fffffff, 32'h00000001, 6'd3);
      send_op(OPCODE_RTYPE, FUNCT_ADDU, 32'hffffffff, 32'hffffffff, 6'd4);
      send_op(OPCODE_RTYPE, FUNCT_SUB,  32'h80000000, 32'h00000001, 6'd5);
      send_op(OPCODE_RTYPE, FUNCT_SUB,  32'h00000005, 32'h00000007, 6'd6);
      send_op(OPCODE_RTYPE, FUNCT_SUBU, 32'h00000000, 32'h00000001, 6'd7);
      send_op(OPCODE_RTYPE, FUNCT_AND,  32'hf0f0f0f0, 32'hff00ff00, 6'd8);
      send_op(OPCODE_RTYPE, FUNCT_OR,   32'h12340000, 32'h00005678, 6'd9);
      send_op(OPCODE_RTYPE, FUNCT_NOR,  32'h00000000, 32'h00000000, 6'd10);
      send_op(OPCODE_RTYPE, FUNCT_SLT,  32'hffffffff, 32'h00000001, 6'd11);
      send_op(OPCODE_RTYPE, FUNCT_SLTU, 32'hffffffff, 32'h00000001, 6'd12);
      send_op(OPCODE_RTYPE, FUNCT_SLT,  32'h00000001, 32'hffffffff, 6'd13);
      send_op(OPCODE_RTYPE, FUNCT_SLTU, 32'h00000001, 32'hffffffff, 6'd14);
      finish_test("directed arithmetic");

      send_op(OPCODE_BEQ, '0, 32'h0000abcd, 32'h0000abcd, 6'd20);
      send_op(OPCODE_BEQ, '0, 32'h0000abcd, 32'h0000abce, 6'd21);
      send_op(OPCODE_BNE, '0, 32'h80000000, 32'h80000000, 6'd22);
      send_op(OPCODE_BNE, '0, 32'h80000000, 32'h00000000, 6'd23);
      finish_test("branches");

      repeat (N_RANDOM) random_op();
      finish_test("random mix");

      stall_pct = 40;
      repeat (N_RANDOM) random_op();
      finish_test("back-pressure");
      stall_pct = 0;

      random_op();
      send_op(OPCODE_RTYPE, 6'h00, 32'h1, 32'h2, 6'd40);   // sll, not decoded here
      random_op();
      send_op(6'h08, '0, 32'h3, 32'h4, 6'd41);
      send_op(6'h23, '0, 32'h5, 32'h6, 6'd42);
      random_op();
      send_op(OPCODE_RTYPE, 6'h26, 32'h7, 32'h8, 6'd43);   // xor
      random_op();
      send_op(6'h02, '0, 32'h9, 32'ha, 6'd44);
      finish_test("illegal encodings");

      stall_pct = 100;
      @(negedge clk);
      repeat (ISSUE_DEPTH) random_op();
      @(negedge clk);
      op_valid = 1'b0;
      repeat (8) begin
         if (op_ready) ready_stuck = 1'b1;
         @(negedge clk);
      end
      if (ready_stuck) begin
         local_errors++;
         $display("op_ready stayed high after %0d ops with the result bus stalled", ISSUE_DEPTH);
      end
      stall_pct = 0;
      repeat (ISSUE_DEPTH) random_op();
      finish_test("credit limit");

      $display("%0d tests, %0d checks, %0d errors", tests_done, check_count,
               error_count + local_errors);
      if (error_count + local_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
design/isa_pkg.sv
design/issue_pkg.sv
design/cla_adder.sv
design/dispatch_unit.sv
design/issue_queue.sv
design/int_exec_unit.sv
design/int_issue_top.sv
verification/int_issue_checker.sv
verification/int_issue_tb.sv
